// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_saturn_decode
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/exec_unit.sv ====
module exec_unit import saturn_pkg::*; #(
  parameter int RSTK_DEPTH = 8
) (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_ins_valid,
  input  ins_op_t             i_ins_op,
  input  logic [ADDR_W-1:0]   i_ins_addr,
  input  logic [IMM_W-1:0]    i_imm,
  output logic                o_ins_done,
  output ins_op_t             o_ins_op,
  output logic [ADDR_W-1:0]   o_ins_addr,
  output logic [IMM_W-1:0]    o_imm,
  output logic                o_jump,
  output logic [ADDR_W-1:0]   o_jump_target,
  output logic [3:0]          o_reg_p,
  output logic                o_mode_dec,
  output logic                o_carry
);

  localparam int PTR_W = $clog2(RSTK_DEPTH);
  localparam int LVL_W = $clog2(RSTK_DEPTH + 1);

  // circular return stack, rstk_ptr is the next free slot
  logic [ADDR_W-1:0] rstk [RSTK_DEPTH];
  logic [PTR_W-1:0] rstk_ptr;
  logic [LVL_W-1:0] rstk_cnt;

  logic is_rtn;
  logic do_push;
  logic do_pop;
  logic [ADDR_W-1:0] off8;
  logic [ADDR_W-1:0] off12;
  logic [ADDR_W-1:0] pop_addr;
  logic [ADDR_W-1:0] target;
  logic jump;

  // signed offsets, relative to the nibble after the opcode
  assign off8 = {{(ADDR_W-8){i_imm[7]}}, i_imm[7:0]};
  assign off12 = {{(ADDR_W-12){i_imm[11]}}, i_imm[11:0]};

  // empty stack pops zero
  assign pop_addr = (rstk_cnt == '0) ? '0 : rstk[rstk_ptr - PTR_W'(1)];

  assign is_rtn = (i_ins_op == OP_RTN) || (i_ins_op == OP_RTNSXM) ||
                  (i_ins_op == OP_RTNSC) || (i_ins_op == OP_RTNCC);
  assign do_push = i_ins_valid && (i_ins_op == OP_GOSUB);
  assign do_pop = i_ins_valid && is_rtn;

  always_comb begin
    target = '0;
    jump = 1'b0;
    case (i_ins_op)
      OP_GOTO, OP_GOSUB: begin
        target = i_ins_addr + ADDR_W'(1) + off12;
        jump = 1'b1;
      end
      OP_GOC, OP_GONC: begin
        target = i_ins_addr + ADDR_W'(1) + off8;
        jump = (i_ins_op == OP_GOC) ? o_carry : !o_carry;
      end
      OP_RTN, OP_RTNSXM, OP_RTNSC, OP_RTNCC: begin
        target = pop_addr;
        jump = 1'b1;
      end
      default: ;
    endcase
  end

  // machine state
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_reg_p <= '0;
      o_mode_dec <= 1'b0;
      o_carry <= 1'b0;
      rstk_ptr <= '0;
      rstk_cnt <= '0;
    end else begin
      if (i_ins_valid) begin
        case (i_ins_op)
          OP_SETHEX: o_mode_dec <= 1'b0;
          OP_SETDEC: o_mode_dec <= 1'b1;
          OP_PINC: o_reg_p <= o_reg_p + 4'd1;
          OP_PDEC: o_reg_p <= o_reg_p - 4'd1;
          OP_PSET: o_reg_p <= i_imm[3:0];
          OP_RTNSC: o_carry <= 1'b1;
          OP_RTNCC: o_carry <= 1'b0;
          default: ;
        endcase
      end
      // a full stack loses its oldest entry, the count saturates
      if (do_push) begin
        rstk_ptr <= rstk_ptr + PTR_W'(1);
        if (rstk_cnt != LVL_W'(RSTK_DEPTH)) begin
          rstk_cnt <= rstk_cnt + LVL_W'(1);
        end
      end
      if (do_pop && rstk_cnt != '0) begin
        rstk_ptr <= rstk_ptr - PTR_W'(1);
        rstk_cnt <= rstk_cnt - LVL_W'(1);
      end
    end
  end

  // return address is the nibble after the 4-nibble GOSUB
  always_ff @(posedge i_clk) begin
    if (do_push) begin
      rstk[rstk_ptr] <= i_ins_addr + ADDR_W'(4);
    end
  end

  // result record
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_ins_done <= 1'b0;
      o_jump <= 1'b0;
    end else begin
      o_ins_done <= i_ins_valid;
      o_jump <= i_ins_valid && jump;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ins_valid) begin
      o_ins_op <= i_ins_op;
      o_ins_addr <= i_ins_addr;
      o_imm <= i_imm;
      o_jump_target <= target;
    end
  end

endmodule

// ==== hw/nibble_decoder.sv ====
module nibble_decoder import saturn_pkg::*; (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_en_dec,
  input  logic [ADDR_W-1:0]   i_pc,
  input  logic [NIBBLE_W-1:0] i_nibble,
  input  logic [CNT_W-1:0]    i_count,
  input  logic [IMM_W-1:0]    i_imm,
  output logic                o_clear,
  output logic                o_shift,
  output logic [NIBBLE_W-1:0] o_shift_nibble,
  output logic                o_ins_valid,
  output ins_op_t             o_ins_op,
  output logic [ADDR_W-1:0]   o_ins_addr,
  output logic [IMM_W-1:0]    o_imm,
  output logic                o_dec_error
);

  dec_state_t state;

  // expected operand length, in nibbles
  logic [CNT_W-1:0] op_len;
  // next operand nibble is the first one
  logic first_opnd;

  // first nibble dispatch
  dec_state_t first_state;
  ins_op_t first_op;
  logic [CNT_W-1:0] first_len;
  logic first_ok;

  // 0x second nibble
  ins_op_t b0_op;
  logic b0_ok;

  logic [CNT_W-1:0] cnt_eff;
  logic last_nibble;

  // collector strobes follow the incoming nibble directly
  assign o_shift = i_en_dec && (state == ST_OPERAND || state == ST_PSET);
  assign o_shift_nibble = i_nibble;

  // 0x clears too, so a record without operand carries a zero immediate
  assign o_clear = i_en_dec && (state == ST_BLOCK0 || state == ST_PSET ||
                                (state == ST_OPERAND && first_opnd));

  assign o_imm = i_imm;

  // count held before this shift, the collector restarts on clear
  assign cnt_eff = first_opnd ? '0 : i_count;
  assign last_nibble = (cnt_eff + CNT_W'(1)) == op_len;

  always_comb begin
    first_state = ST_FIRST;
    first_op = OP_RTN;
    first_len = CNT_W'(2);
    first_ok = 1'b1;
    case (i_nibble)
      4'h0: first_state = ST_BLOCK0;
      4'h2: begin
        first_state = ST_PSET;
        first_op = OP_PSET;
      end
      4'h3: begin
        first_state = ST_LCLEN;
        first_op = OP_LC;
      end
      // 4xy GOC, 5xy GONC
      4'h4, 4'h5: begin
        first_state = ST_OPERAND;
        first_op = i_nibble[0] ? OP_GONC : OP_GOC;
      end
      // 6xyz GOTO, 7xyz GOSUB
      4'h6, 4'h7: begin
        first_state = ST_OPERAND;
        first_op = i_nibble[0] ? OP_GOSUB : OP_GOTO;
        first_len = CNT_W'(3);
      end
      default: first_ok = 1'b0;
    endcase
  end

  always_comb begin
    b0_op = OP_RTN;
    b0_ok = 1'b1;
    case (i_nibble)
      4'h0: b0_op = OP_RTNSXM;
      4'h1: b0_op = OP_RTN;
      4'h2: b0_op = OP_RTNSC;
      4'h3: b0_op = OP_RTNCC;
      4'h4: b0_op = OP_SETHEX;
      4'h5: b0_op = OP_SETDEC;
      4'hC: b0_op = OP_PINC;
      4'hD: b0_op = OP_PDEC;
      default: b0_ok = 1'b0;
    endcase
  end

  // FSM and status pulses
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= ST_FIRST;
      first_opnd <= 1'b0;
      o_ins_valid <= 1'b0;
      o_dec_error <= 1'b0;
    end else begin
      o_ins_valid <= 1'b0;
      o_dec_error <= 1'b0;
      if (i_en_dec) begin
        case (state)
          ST_FIRST: begin
            state <= first_state;
            first_opnd <= 1'b1;
            o_dec_error <= !first_ok;
          end
          ST_BLOCK0: begin
            state <= ST_FIRST;
            o_ins_valid <= b0_ok;
            o_dec_error <= !b0_ok;
          end
          // any n is legal
          ST_PSET: begin
            state <= ST_FIRST;
            o_ins_valid <= 1'b1;
          end
          ST_LCLEN: begin
            state <= ST_OPERAND;
            first_opnd <= 1'b1;
          end
          ST_OPERAND: begin
            first_opnd <= 1'b0;
            if (last_nibble) begin
              state <= ST_FIRST;
              o_ins_valid <= 1'b1;
            end
          end
          default: state <= ST_FIRST;
        endcase
      end
    end
  end

  // pending instruction fields
  always_ff @(posedge i_clk) begin
    if (i_en_dec) begin
      if (state == ST_FIRST) begin
        o_ins_addr <= i_pc;
        o_ins_op <= first_op;
        op_len <= first_len;
      end else if (state == ST_BLOCK0) begin
        o_ins_op <= b0_op;
      end else if (state == ST_LCLEN) begin
        // 3n loads n+1 nibbles
        op_len <= CNT_W'(i_nibble) + CNT_W'(1);
      end
    end
  end

endmodule

// ==== hw/operand_collector.sv ====
module operand_collector import saturn_pkg::*; (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_clear,
  input  logic                i_shift,
  input  logic [NIBBLE_W-1:0] i_nibble,
  output logic [IMM_W-1:0]    o_imm,
  output logic [CNT_W-1:0]    o_count
);

  // slot taken by the current shift
  logic [CNT_W-1:0] slot;
  logic slot_free;

  assign slot = i_clear ? '0 : o_count;
  assign slot_free = slot < CNT_W'(IMM_NIBBLES);

  // nibble count, restarts on clear
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_count <= '0;
    end else if (i_shift && slot_free) begin
      o_count <= slot + CNT_W'(1);
    end else if (i_clear) begin
      o_count <= '0;
    end
  end

  // low nibble first, unused slots stay zero after a clear
  always_ff @(posedge i_clk) begin
    if (i_clear) begin
      o_imm <= '0;
    end
    if (i_shift && slot_free) begin
      o_imm[slot*NIBBLE_W +: NIBBLE_W] <= i_nibble;
    end
  end

endmodule

// ==== hw/saturn_decode_top.sv ====
module saturn_decode_top import saturn_pkg::*; #(
  parameter int RSTK_DEPTH = 8
) (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_en_dec,
  input  logic [ADDR_W-1:0]   i_pc,
  input  logic [NIBBLE_W-1:0] i_nibble,
  output logic                o_ins_done,
  output ins_op_t             o_ins_op,
  output logic [ADDR_W-1:0]   o_ins_addr,
  output logic [IMM_W-1:0]    o_imm,
  output logic                o_jump,
  output logic [ADDR_W-1:0]   o_jump_target,
  output logic [3:0]          o_reg_p,
  output logic                o_mode_dec,
  output logic                o_carry,
  output logic                o_dec_error
);

  // decoder to collector
  logic clear;
  logic shift;
  logic [NIBBLE_W-1:0] shift_nibble;
  logic [IMM_W-1:0] coll_imm;
  logic [CNT_W-1:0] coll_count;

  // decoder to execute unit
  logic ins_valid;
  ins_op_t dec_op;
  logic [ADDR_W-1:0] dec_addr;
  logic [IMM_W-1:0] dec_imm;

  nibble_decoder decoder_i (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_en_dec       (i_en_dec),
    .i_pc           (i_pc),
    .i_nibble       (i_nibble),
    .i_count        (coll_count),
    .i_imm          (coll_imm),
    .o_clear        (clear),
    .o_shift        (shift),
    .o_shift_nibble (shift_nibble),
    .o_ins_valid    (ins_valid),
    .o_ins_op       (dec_op),
    .o_ins_addr     (dec_addr),
    .o_imm          (dec_imm),
    .o_dec_error    (o_dec_error)
  );

  operand_collector collector_i (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_clear  (clear),
    .i_shift  (shift),
    .i_nibble (shift_nibble),
    .o_imm    (coll_imm),
    .o_count  (coll_count)
  );

  exec_unit #(
    .RSTK_DEPTH (RSTK_DEPTH)
  ) exec_i (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_ins_valid   (ins_valid),
    .i_ins_op      (dec_op),
    .i_ins_addr    (dec_addr),
    .i_imm         (dec_imm),
    .o_ins_done    (o_ins_done),
    .o_ins_op      (o_ins_op),
    .o_ins_addr    (o_ins_addr),
    .o_imm         (o_imm),
    .o_jump        (o_jump),
    .o_jump_target (o_jump_target),
    .o_reg_p       (o_reg_p),
    .o_mode_dec    (o_mode_dec),
    .o_carry       (o_carry)
  );

endmodule

// ==== hw/saturn_pkg.sv ====
package saturn_pkg;

  // bus and register widths
  localparam int NIBBLE_W = 4;
  localparam int ADDR_W = 20;

  // longest LC immediate, in nibbles
  localparam int IMM_NIBBLES = 16;
  localparam int IMM_W = NIBBLE_W * IMM_NIBBLES;

  // wide enough to hold a count of IMM_NIBBLES
  localparam int CNT_W = 5;

  // decoder FSM states
  typedef enum logic [2:0] {
    ST_FIRST   = 3'd0,
    // second nibble of 0x
    ST_BLOCK0  = 3'd1,
    // n of 2n
    ST_PSET    = 3'd2,
    // length nibble of 3n
    ST_LCLEN   = 3'd3,
    ST_OPERAND = 3'd4
  } dec_state_t;

  // decoded operations
  typedef enum logic [3:0] {
    OP_RTN    = 4'd0,
    OP_RTNSXM = 4'd1,
    OP_RTNSC  = 4'd2,
    OP_RTNCC  = 4'd3,
    OP_SETHEX = 4'd4,
    OP_SETDEC = 4'd5,
    OP_PINC   = 4'd6,
    OP_PDEC   = 4'd7,
    OP_PSET   = 4'd8,
    OP_LC     = 4'd9,
    OP_GOC    = 4'd10,
    OP_GONC   = 4'd11,
    OP_GOTO   = 4'd12,
    OP_GOSUB  = 4'd13
  } ins_op_t;

endpackage

// ==== sim.f ====
hw/saturn_pkg.sv
hw/operand_collector.sv
hw/nibble_decoder.sv
hw/exec_unit.sv
hw/saturn_decode_top.sv
tb/saturn_decode_props.sv
tb/tb_saturn_decode.sv

// ==== tb/saturn_decode_props.sv ====
module saturn_decode_props #(
  parameter int RSTK_DEPTH = 8
) (
  input logic                             i_clk,
  input logic                             i_reset,
  input logic                             i_ins_valid,
  input logic                             i_dec_error,
  input logic                             i_ins_done,
  input logic [$clog2(RSTK_DEPTH+1)-1:0]  i_rstk_cnt
);

  // a nibble either completes an instruction or is rejected
  a_valid_or_error: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_ins_valid && i_dec_error))
    else $error("instruction valid and decode error high together");

  a_valid_to_done: assert property (@(posedge i_clk) disable iff (i_reset)
    i_ins_valid |=> i_ins_done)
    else $error("valid pulse not followed by done");

  a_done_from_valid: assert property (@(posedge i_clk) disable iff (i_reset)
    i_ins_done |-> $past(i_ins_valid))
    else $error("done pulse without a valid pulse one cycle before");

  a_stack_depth: assert property (@(posedge i_clk) disable iff (i_reset)
    i_rstk_cnt <= RSTK_DEPTH)
    else $error("return stack depth above its size");

endmodule

bind saturn_decode_top saturn_decode_props #(.RSTK_DEPTH(RSTK_DEPTH)) props_i (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .i_ins_valid (decoder_i.o_ins_valid),
  .i_dec_error (decoder_i.o_dec_error),
  .i_ins_done  (exec_i.o_ins_done),
  .i_rstk_cnt  (exec_i.rstk_cnt)
);

// ==== tb/tb_saturn_decode.sv ====
module tb_saturn_decode import saturn_pkg::*; ();

  localparam int RSTK_DEPTH = 8;
  localparam int NUM_INS = 400;
  // up to 20 nibbles per instruction, each with a gap of up to 3 cycles
  localparam int TIMEOUT_CYCLES = NUM_INS * 20 * 4;
  localparam logic [31:0] SEED = 32'h51143409;

  typedef struct packed {
    ins_op_t           op;
    logic [ADDR_W-1:0] addr;
    logic [IMM_W-1:0]  imm;
    logic              jump;
    logic [ADDR_W-1:0] target;
    logic [3:0]        p;
    logic              mode_dec;
    logic              carry;
  } rec_t;

  logic                i_clk;
  logic                i_reset;
  logic                i_en_dec;
  logic [ADDR_W-1:0]   i_pc;
  logic [NIBBLE_W-1:0] i_nibble;
  logic                o_ins_done;
  ins_op_t             o_ins_op;
  logic [ADDR_W-1:0]   o_ins_addr;
  logic [IMM_W-1:0]    o_imm;
  logic                o_jump;
  logic [ADDR_W-1:0]   o_jump_target;
  logic [3:0]          o_reg_p;
  logic                o_mode_dec;
  logic                o_carry;
  logic                o_dec_error;

  // reference machine state, newest stack entry at the back
  logic [3:0] m_p;
  logic m_mode_dec;
  logic m_carry;
  logic [ADDR_W-1:0] m_stack[$];

  rec_t exp_q[$];
  rec_t exp_rec;
  logic [ADDR_W-1:0] pc;
  int errors = 0;
  int records = 0;
  int exp_dec_errors = 0;
  int seen_dec_errors = 0;
  int issued = 0;
  int cycles = 0;

  saturn_decode_top #(
    .RSTK_DEPTH (RSTK_DEPTH)
  ) dut_i (
    .i_clk         (i_clk),
    .i_reset       (i_reset),
    .i_en_dec      (i_en_dec),
    .i_pc          (i_pc),
    .i_nibble      (i_nibble),
    .o_ins_done    (o_ins_done),
    .o_ins_op      (o_ins_op),
    .o_ins_addr    (o_ins_addr),
    .o_imm         (o_imm),
    .o_jump        (o_jump),
    .o_jump_target (o_jump_target),
    .o_reg_p       (o_reg_p),
    .o_mode_dec    (o_mode_dec),
    .o_carry       (o_carry),
    .o_dec_error   (o_dec_error)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  // expected record of one instruction, advances the model state
  function automatic rec_t ref_exec(input ins_op_t op, input logic [ADDR_W-1:0] addr,
                                    input logic [IMM_W-1:0] imm);
    rec_t r;
    logic [ADDR_W-1:0] off8;
    logic [ADDR_W-1:0] off12;
    off8 = ADDR_W'($signed(imm[7:0]));
    off12 = ADDR_W'($signed(imm[11:0]));
    r = '0;
    r.op = op;
    r.addr = addr;
    r.imm = imm;
    case (op)
      OP_GOTO, OP_GOSUB: begin
        r.jump = 1'b1;
        r.target = addr + ADDR_W'(1) + off12;
        if (op == OP_GOSUB) begin
          m_stack.push_back(addr + ADDR_W'(4));
          // oldest entry falls off a full stack
          if (m_stack.size() > RSTK_DEPTH) begin
            m_stack.delete(0);
          end
        end
      end
      OP_GOC, OP_GONC: begin
        r.jump = (op == OP_GOC) ? m_carry : !m_carry;
        r.target = addr + ADDR_W'(1) + off8;
      end
      OP_RTN, OP_RTNSXM, OP_RTNSC, OP_RTNCC: begin
        r.jump = 1'b1;
        if (m_stack.size() != 0) begin
          r.target = m_stack.pop_back();
        end
        if (op == OP_RTNSC) begin
          m_carry = 1'b1;
        end else if (op == OP_RTNCC) begin
          m_carry = 1'b0;
        end
      end
      OP_SETHEX: m_mode_dec = 1'b0;
      OP_SETDEC: m_mode_dec = 1'b1;
      OP_PINC: m_p = m_p + 4'd1;
      OP_PDEC: m_p = m_p - 4'd1;
      OP_PSET: m_p = imm[3:0];
      default: ;
    endcase
    r.p = m_p;
    r.mode_dec = m_mode_dec;
    r.carry = m_carry;
    return r;
  endfunction

  // second nibble of the 0x group
  function automatic logic [NIBBLE_W-1:0] block0_code(input ins_op_t op);
    case (op)
      OP_RTNSXM: return 4'h0;
      OP_RTN: return 4'h1;
      OP_RTNSC: return 4'h2;
      OP_RTNCC: return 4'h3;
      OP_SETHEX: return 4'h4;
      OP_SETDEC: return 4'h5;
      OP_PINC: return 4'hC;
      default: return 4'hD;
    endcase
  endfunction

  function automatic logic is_branch(input ins_op_t op);
    return op == OP_GOC || op == OP_GONC || op == OP_GOTO || op == OP_GOSUB ||
           op == OP_RTN || op == OP_RTNSXM || op == OP_RTNSC || op == OP_RTNCC;
  endfunction

  task automatic check_op(input string name, input ins_op_t got, input ins_op_t exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                            input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_imm(input string name, input logic [IMM_W-1:0] got,
                           input logic [IMM_W-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_nibble(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // one nibble with an occasional idle gap in front
  task automatic send_nibble(input logic [NIBBLE_W-1:0] nib);
    int gap;
    gap = 0;
    if ($urandom_range(0, 5) == 0) begin
      gap = $urandom_range(1, 3);
    end
    repeat (gap) begin
      @(posedge i_clk);
      i_en_dec <= 1'b0;
    end
    @(posedge i_clk);
    i_en_dec <= 1'b1;
    i_nibble <= nib;
    i_pc <= pc;
    pc = pc + ADDR_W'(1);
  endtask

  task automatic issue(input ins_op_t op, input logic [IMM_W-1:0] operand, input int lc_len);
    logic [IMM_W-1:0] imm;
    logic [NIBBLE_W-1:0] first;
    int n;
    int i;
    imm = '0;
    first = 4'h0;
    n = 0;
    case (op)
      OP_PSET: begin
        first = 4'h2;
        n = 1;
      end
      OP_LC: begin
        first = 4'h3;
        n = lc_len;
      end
      OP_GOC, OP_GONC: begin
        first = (op == OP_GOC) ? 4'h4 : 4'h5;
        n = 2;
      end
      OP_GOTO, OP_GOSUB: begin
        first = (op == OP_GOTO) ? 4'h6 : 4'h7;
        n = 3;
      end
      default: ;
    endcase
    // operand nibbles low first, zero above them
    for (i = 0; i < n; i++) begin
      imm[i*4 +: 4] = operand[i*4 +: 4];
    end
    exp_q.push_back(ref_exec(op, pc, imm));
    issued++;
    send_nibble(first);
    if (first == 4'h0) begin
      send_nibble(block0_code(op));
    end else if (op == OP_LC) begin
      send_nibble(4'(lc_len - 1));
    end
    for (i = 0; i < n; i++) begin
      send_nibble(imm[i*4 +: 4]);
    end
  endtask

  task automatic issue_bad(input logic [NIBBLE_W-1:0] nib, input logic after_zero);
    exp_dec_errors++;
    issued++;
    if (after_zero) begin
      send_nibble(4'h0);
    end
    send_nibble(nib);
  endtask

  task automatic issue_random();
    int sel;
    int k;
    ins_op_t op;
    logic [IMM_W-1:0] operand;
    sel = $urandom_range(0, 99);
    operand = {$urandom(), $urandom()};
    if (sel < 5) begin
      // bad first nibble: 1 or 8..F
      k = $urandom_range(0, 8);
      issue_bad((k == 0) ? 4'h1 : 4'(k + 7), 1'b0);
    end else if (sel < 10) begin
      // bad second nibble after 0: 6..B, E, F
      k = $urandom_range(0, 7);
      issue_bad((k < 6) ? 4'(k + 6) : 4'(k + 8), 1'b1);
    end else begin
      op = ins_op_t'(4'($urandom_range(0, 13)));
      issue(op, operand, $urandom_range(1, 16));
    end
  endtask

  always @(posedge i_clk) begin
    if (!i_reset) begin
      if (o_dec_error) begin
        seen_dec_errors++;
      end
      if (o_ins_done) begin
        if (exp_q.size() == 0) begin
          $display("t=%0t result record arrived with no instruction outstanding", $time);
          errors++;
        end else begin
          exp_rec = exp_q.pop_front();
          records++;
          check_op("o_ins_op", o_ins_op, exp_rec.op);
          check_addr("o_ins_addr", o_ins_addr, exp_rec.addr);
          check_imm("o_imm", o_imm, exp_rec.imm);
          check_bit("o_jump", o_jump, exp_rec.jump);
          if (is_branch(exp_rec.op)) begin
            check_addr("o_jump_target", o_jump_target, exp_rec.target);
          end
          check_nibble("o_reg_p", o_reg_p, exp_rec.p);
          check_bit("o_mode_dec", o_mode_dec, exp_rec.mode_dec);
          check_bit("o_carry", o_carry, exp_rec.carry);
        end
      end
    end
  end

  initial begin
    int k;
    int len;
    i_reset = 1'b1;
    i_en_dec = 1'b0;
    i_pc = '0;
    i_nibble = '0;
    pc = '0;
    m_p = 4'h0;
    m_mode_dec = 1'b0;
    m_carry = 1'b0;
    void'($urandom(SEED));
    repeat (5) @(posedge i_clk);
    i_reset <= 1'b0;
    check_bit("o_ins_done", o_ins_done, 1'b0);
    check_bit("o_jump", o_jump, 1'b0);
    check_bit("o_dec_error", o_dec_error, 1'b0);
    check_nibble("o_reg_p", o_reg_p, 4'h0);
    check_bit("o_mode_dec", o_mode_dec, 1'b0);
    check_bit("o_carry", o_carry, 1'b0);

    // mode bit and P wrap
    issue(OP_SETDEC, '0, 1);
    issue(OP_SETHEX, '0, 1);
    issue(OP_SETDEC, '0, 1);
    issue(OP_PSET, 64'hF, 1);
    issue(OP_PINC, '0, 1);
    issue(OP_PDEC, '0, 1);
    issue(OP_PSET, 64'h7, 1);
    issue(OP_PDEC, '0, 1);
    for (len = 1; len <= 16; len++) begin
      issue(OP_LC, {$urandom(), $urandom()}, len);
    end
    // carry, conditional branches, pops from an empty stack
    issue(OP_RTNSC, '0, 1);
    issue(OP_GOC, 64'h80, 1);
    issue(OP_GONC, 64'h7F, 1);
    issue(OP_RTNCC, '0, 1);
    issue(OP_GOC, 64'h35, 1);
    issue(OP_GONC, 64'hF0, 1);
    issue(OP_GOTO, 64'h800, 1);
    issue(OP_GOTO, 64'h7FF, 1);
    // overflow the return stack, then drain it past empty
    for (k = 0; k < RSTK_DEPTH + 2; k++) begin
      issue(OP_GOSUB, {$urandom(), $urandom()}, 1);
    end
    for (k = 0; k < RSTK_DEPTH + 3; k++) begin
      issue((k % 2 == 0) ? OP_RTNSXM : OP_RTN, '0, 1);
    end
    issue_bad(4'hA, 1'b0);
    issue(OP_PINC, '0, 1);
    issue_bad(4'hE, 1'b1);
    issue(OP_SETHEX, '0, 1);
    while (issued < NUM_INS - 1) begin
      issue_random();
    end
    issue(OP_PSET, 64'h3, 1);
    @(posedge i_clk);
    i_en_dec <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (2) @(posedge i_clk);

    if (seen_dec_errors != exp_dec_errors) begin
      $display("decode error pulses: saw %0d, expected %0d", seen_dec_errors, exp_dec_errors);
      errors++;
    end
    $display("summary: %0d errors, %0d records checked, %0d decode errors", errors, records,
             seen_dec_errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
